// ==== rtl/ic_pkg.sv ====
// Widths, payload types and reset constants for the cache RAM block.
// The line width is also the bus data width; key and nonce must stay equal
// in width, since the keystream word is their XOR.

package ic_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  parameter int unsigned KEY_W   = 32;
  parameter int unsigned NONCE_W = 32;
  parameter int unsigned TAG_W   = 22;
  parameter int unsigned LINE_W  = 64;

  //////////////////////////////
  // Payload types
  //////////////////////////////

  typedef logic [KEY_W-1:0]   key_t;
  typedef logic [NONCE_W-1:0] nonce_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [LINE_W-1:0]  line_t;

  //////////////////////////////
  // Reset values
  //////////////////////////////

  // Key in use until the first rekey
  parameter key_t   RST_KEY   = 32'h9e37_79b9;
  parameter nonce_t RST_NONCE = 32'h7f4a_7c15;

endpackage

// ==== rtl/ic_ram_if.sv ====
// Request and read data between the bank selector and one RAM bank.
// Read data is valid the cycle after a read request and held until the next.

`timescale 1ns/100ps

interface ic_ram_if #(
  parameter type         data_t   = ic_pkg::line_t,
  parameter int unsigned NumLines = 16
);

  localparam int unsigned IdxW = $clog2(NumLines);

  logic            req;
  logic            we;
  logic [IdxW-1:0] addr;
  data_t           wdata;
  data_t           rdata;

  modport master (
    output req, we, addr, wdata,
    input  rdata
  );

  modport bank (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

// ==== rtl/ic_scramble_ctrl.sv ====
// Key and nonce registers with the rekey handshake.
// Key and nonce load on any cycle with scramble_key_valid_i high;
// invalidate_i is ignored while a key request is pending.

`timescale 1ns/100ps

module ic_scramble_ctrl (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           invalidate_i,
  input  logic           scramble_key_valid_i,
  input  ic_pkg::key_t   scramble_key_i,
  input  ic_pkg::nonce_t scramble_nonce_i,
  output logic           scramble_req_o,
  output logic           key_valid_o,
  output ic_pkg::key_t   key_o,
  output ic_pkg::nonce_t nonce_o
);

  logic           req_d, req_q;
  logic           valid_d, valid_q;
  ic_pkg::key_t   key_q;
  ic_pkg::nonce_t nonce_q;

  // Pending request stays up until the provider answers
  assign req_d   = req_q ? ~scramble_key_valid_i : invalidate_i;
  assign valid_d = req_q        ? scramble_key_valid_i :
                   invalidate_i ? 1'b0                 :
                                  valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= ic_pkg::RST_KEY;
      nonce_q <= ic_pkg::RST_NONCE;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

endmodule

// ==== rtl/ic_scr_ram.sv ====
// Single-port RAM with an XOR keystream on both write and read.
// The keystream uses the key present at access time; entries written under an
// older key read back garbled. Key validity is not checked here.

`timescale 1ns/100ps

module ic_scr_ram #(
  parameter type         data_t   = ic_pkg::line_t,
  parameter int unsigned NumLines = 16
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ic_pkg::key_t   key_i,
  input  ic_pkg::nonce_t nonce_i,
  ic_ram_if.bank         bank_port
);

  localparam int unsigned DataW = $bits(data_t);

  data_t              mem [NumLines];
  data_t              rdata_q;
  ic_pkg::key_t       ks_word;
  logic [DataW-1:0]   ks;

  //////////////////////////////
  // Keystream
  //////////////////////////////

  assign ks_word = key_i ^ nonce_i ^ ic_pkg::key_t'(bank_port.addr);

  // Word repeated across the payload, top copy truncated
  always_comb begin
    for (int i = 0; i < DataW; i++) begin
      ks[i] = ks_word[i % ic_pkg::KEY_W];
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (bank_port.req && bank_port.we) begin
      mem[bank_port.addr] <= data_t'(bank_port.wdata ^ ks);
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (bank_port.req && !bank_port.we) begin
      rdata_q <= data_t'(mem[bank_port.addr] ^ ks);
    end
  end

  assign bank_port.rdata = rdata_q;

endmodule

// ==== rtl/ic_bank_select.sv ====
// Grants bus requests while the key is valid and steers them to one bank.
// Read data returns exactly one cycle after acceptance; tags are
// zero-extended to the line width. Writes get no response.

`timescale 1ns/100ps

module ic_bank_select #(
  parameter int unsigned NumWays  = 2,
  parameter int unsigned NumLines = 16,
  localparam int unsigned WayW    = (NumWays > 1) ? $clog2(NumWays) : 1,
  localparam int unsigned IdxW    = $clog2(NumLines)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            key_valid_i,
  input  logic            req_i,
  input  logic            we_i,
  input  logic            sel_line_i,
  input  logic [WayW-1:0] way_i,
  input  logic [IdxW-1:0] addr_i,
  input  ic_pkg::line_t   wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output ic_pkg::line_t   rdata_o,
  ic_ram_if.master        tag_ports  [NumWays],
  ic_ram_if.master        line_ports [NumWays]
);

  logic            accept;
  logic            rvalid_q;
  logic            sel_line_q;
  logic [WayW-1:0] way_q;
  ic_pkg::tag_t    tag_rdata  [NumWays];
  ic_pkg::line_t   line_rdata [NumWays];

  // Grant follows the key alone, requester holds its request meanwhile
  assign gnt_o  = key_valid_i;
  assign accept = req_i & gnt_o;

  //////////////////////////////
  // Request routing
  //////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    assign tag_ports[w].req   = accept & ~sel_line_i & (way_i == WayW'(w));
    assign tag_ports[w].we    = we_i;
    assign tag_ports[w].addr  = addr_i;
    assign tag_ports[w].wdata = wdata_i[ic_pkg::TAG_W-1:0];
    assign tag_rdata[w]       = tag_ports[w].rdata;

    assign line_ports[w].req   = accept & sel_line_i & (way_i == WayW'(w));
    assign line_ports[w].we    = we_i;
    assign line_ports[w].addr  = addr_i;
    assign line_ports[w].wdata = wdata_i;
    assign line_rdata[w]       = line_ports[w].rdata;
  end

  //////////////////////////////
  // Read return
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q   <= 1'b0;
      sel_line_q <= 1'b0;
      way_q      <= '0;
    end else begin
      rvalid_q <= accept & ~we_i;
      if (accept && !we_i) begin
        sel_line_q <= sel_line_i;
        way_q      <= way_i;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = sel_line_q ? line_rdata[way_q] :
                                 ic_pkg::line_t'(tag_rdata[way_q]);

endmodule

// ==== rtl/ic_ram_top.sv ====
// Scrambled tag and line banks of the instruction cache, reached over a
// request/grant/rvalid bus. Requests stall while a new key is awaited;
// entries written under an old key are not re-encrypted on rekey.

`timescale 1ns/100ps

module ic_ram_top #(
  parameter int unsigned NumWays  = 2,
  parameter int unsigned NumLines = 16,
  localparam int unsigned WayW    = (NumWays > 1) ? $clog2(NumWays) : 1,
  localparam int unsigned IdxW    = $clog2(NumLines)
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Bus
  input  logic            req_i,
  input  logic            we_i,
  input  logic            sel_line_i,
  input  logic [WayW-1:0] way_i,
  input  logic [IdxW-1:0] addr_i,
  input  ic_pkg::line_t   wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output ic_pkg::line_t   rdata_o,

  // Key provider
  input  logic            invalidate_i,
  input  logic            scramble_key_valid_i,
  input  ic_pkg::key_t    scramble_key_i,
  input  ic_pkg::nonce_t  scramble_nonce_i,
  output logic            scramble_req_o
);

  logic           key_valid;
  ic_pkg::key_t   key;
  ic_pkg::nonce_t nonce;

  ic_ram_if #(.data_t(ic_pkg::tag_t),  .NumLines(NumLines)) tag_if  [NumWays] ();
  ic_ram_if #(.data_t(ic_pkg::line_t), .NumLines(NumLines)) line_if [NumWays] ();

  //////////////////////////////
  // Key management
  //////////////////////////////

  ic_scramble_ctrl u_scramble_ctrl (
    .clk_i,
    .rst_ni,
    .invalidate_i,
    .scramble_key_valid_i,
    .scramble_key_i,
    .scramble_nonce_i,
    .scramble_req_o,
    .key_valid_o (key_valid),
    .key_o       (key),
    .nonce_o     (nonce)
  );

  //////////////////////////////
  // Bus front end
  //////////////////////////////

  ic_bank_select #(
    .NumWays  (NumWays),
    .NumLines (NumLines)
  ) u_bank_select (
    .clk_i,
    .rst_ni,
    .key_valid_i (key_valid),
    .req_i,
    .we_i,
    .sel_line_i,
    .way_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .tag_ports   (tag_if),
    .line_ports  (line_if)
  );

  //////////////////////////////
  // Banks
  //////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_banks
    ic_scr_ram #(
      .data_t   (ic_pkg::tag_t),
      .NumLines (NumLines)
    ) u_tag_bank (
      .clk_i,
      .rst_ni,
      .key_i     (key),
      .nonce_i   (nonce),
      .bank_port (tag_if[w])
    );

    ic_scr_ram #(
      .data_t   (ic_pkg::line_t),
      .NumLines (NumLines)
    ) u_line_bank (
      .clk_i,
      .rst_ni,
      .key_i     (key),
      .nonce_i   (nonce),
      .bank_port (line_if[w])
    );
  end

endmodule

// ==== bench/ic_ram_chk.sv ====
// Bus and key protocol assertions, bound to the RAM top level.
// Checks are disabled while reset is asserted.

`timescale 1ns/100ps

module ic_ram_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic we_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic scramble_req_o
);

  int unsigned fail_count = 0;

  // No grant while a new key is awaited
  a_no_gnt_in_rekey: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scramble_req_o |-> !gnt_o)
    else begin fail_count++; $error("grant high during key request"); end

  a_read_returns: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && gnt_o && !we_i) |=> rvalid_o)
    else begin fail_count++; $error("accepted read without rvalid next cycle"); end

  a_no_spurious_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(req_i && gnt_o && !we_i))
    else begin fail_count++; $error("rvalid without accepted read"); end

  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(scramble_req_o))
    else begin fail_count++; $error("key request unknown after reset"); end

endmodule

// ==== bench/ic_ram_tb.sv ====
// Directed testbench for the scrambled cache RAM top level, default parameters.
// The model keeps plaintext plus the key and nonce in use at write time,
// and only reads entries that were written before.

`timescale 1ns/100ps

module ic_ram_tb;

  localparam int NumWays   = 2;
  localparam int NumLines  = 16;
  localparam int ClkPeriod = 40;
  // Cycle budget per test: reset, readback, back-to-back, stall, old key, repeat
  localparam int TestCycles = 20 + 160 + 40 + 40 + 80 + 120;
  localparam int WatchdogNs = 2 * TestCycles * ClkPeriod;

  logic           clk_i, rst_ni;
  logic           req_i, we_i, sel_line_i;
  logic [0:0]     way_i;
  logic [3:0]     addr_i;
  ic_pkg::line_t  wdata_i, rdata_o;
  logic           gnt_o, rvalid_o;
  logic           invalidate_i, scramble_key_valid_i, scramble_req_o;
  ic_pkg::key_t   scramble_key_i, cur_key;
  ic_pkg::nonce_t scramble_nonce_i, cur_nonce;

  // Indexed [bank][way][line], bank 0 is tag and bank 1 is line
  logic [63:0]    shadow   [2][NumWays][NumLines];
  ic_pkg::key_t   wr_key   [2][NumWays][NumLines];
  ic_pkg::nonce_t wr_nonce [2][NumWays][NumLines];

  ic_ram_top UUT (.*);

  bind ic_ram_top ic_ram_chk u_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .we_i           (we_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .scramble_req_o (scramble_req_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired: a bus or key handshake never completed");
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Key XOR nonce XOR index, repeated across 64 bits
  function automatic logic [63:0] keystream(input logic [31:0] key, input logic [31:0] nonce,
                                            input int idx);
    logic [31:0] word;
    word = key ^ nonce ^ 32'(idx);
    return {word, word};
  endfunction

  function automatic logic [63:0] expected_read(input int sel, input int way, input int idx);
    logic [63:0] v;
    v = shadow[sel][way][idx] ^ keystream(wr_key[sel][way][idx], wr_nonce[sel][way][idx], idx)
        ^ keystream(cur_key, cur_nonce, idx);
    if (sel == 0) begin
      v = {42'b0, v[21:0]};
    end
    return v;
  endfunction

  // Called at a falling edge; returns at the falling edge after acceptance
  task automatic send_req(input logic we, input int sel, input int way, input int idx,
                          input logic [63:0] data);
    req_i      = 1'b1;
    we_i       = we;
    sel_line_i = 1'(sel);
    way_i      = 1'(way);
    addr_i     = 4'(idx);
    wdata_i    = data;
    while (!gnt_o) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic write_entry(input int sel, input int way, input int idx);
    logic [63:0] data;
    data = {$urandom, $urandom};
    send_req(1'b1, sel, way, idx, data);
    req_i = 1'b0;
    check_value(rvalid_o, 1'b0, "rvalid after write");
    shadow[sel][way][idx]   = data;
    wr_key[sel][way][idx]   = cur_key;
    wr_nonce[sel][way][idx] = cur_nonce;
  endtask

  task automatic read_entry(input int sel, input int way, input int idx, input logic keep);
    send_req(1'b0, sel, way, idx, '0);
    if (!keep) req_i = 1'b0;
    check_value(rvalid_o, 1'b1, "rvalid after read");
    check_value(rdata_o, expected_read(sel, way, idx), "read data");
  endtask

  task automatic pulse_invalidate();
    invalidate_i = 1'b1;
    @(negedge clk_i);
    invalidate_i = 1'b0;
  endtask

  task automatic deliver_key();
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = $urandom;
    scramble_nonce_i     = $urandom;
    cur_key              = scramble_key_i;
    cur_nonce            = scramble_nonce_i;
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    check_value(scramble_req_o, 1'b0, "key request after key delivery");
    check_value(gnt_o, 1'b1, "grant after key delivery");
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////

  task automatic reset_and_readback();
    check_value(gnt_o, 1'b1, "grant after reset");
    check_value(scramble_req_o, 1'b0, "key request after reset");
    check_value(rvalid_o, 1'b0, "rvalid after reset");
    for (int s = 0; s < 2; s++)
      for (int w = 0; w < NumWays; w++)
        for (int i = 0; i < NumLines; i++) write_entry(s, w, i);
    for (int s = 0; s < 2; s++)
      for (int w = 0; w < NumWays; w++)
        for (int i = 0; i < NumLines; i++) read_entry(s, w, i, 1'b0);
  endtask

  task automatic back_to_back_reads();
    for (int n = 0; n < 8; n++) begin
      read_entry($urandom % 2, $urandom % NumWays, $urandom % NumLines, 1'b1);
    end
    req_i = 1'b0;
    @(negedge clk_i);
    check_value(rvalid_o, 1'b0, "rvalid after last back-to-back read");
  endtask

  task automatic rekey_stall();
    pulse_invalidate();
    check_value(scramble_req_o, 1'b1, "key request after invalidate");
    check_value(gnt_o, 1'b0, "grant after invalidate");
    fork
      read_entry(1, 0, 5, 1'b0);
      begin
        repeat (6) @(negedge clk_i);
        check_value(gnt_o, 1'b0, "grant while key pending");
        check_value(rvalid_o, 1'b0, "rvalid while key pending");
        deliver_key();
      end
    join
  endtask

  task automatic old_key_reads();
    for (int s = 0; s < 2; s++)
      for (int w = 0; w < NumWays; w++)
        for (int i = 0; i < NumLines; i++) read_entry(s, w, i, 1'b0);
  endtask

  task automatic repeat_invalidate();
    pulse_invalidate();
    @(negedge clk_i);
    pulse_invalidate();
    check_value(scramble_req_o, 1'b1, "key request after second invalidate");
    check_value(gnt_o, 1'b0, "grant after second invalidate");
    deliver_key();
    @(negedge clk_i);
    check_value(scramble_req_o, 1'b0, "key request one cycle after delivery");
    for (int i = 0; i < 8; i++) begin
      write_entry(i % 2, (i / 2) % NumWays, i + 4);
      read_entry(i % 2, (i / 2) % NumWays, i + 4, 1'b0);
    end
    read_entry(0, 1, 15, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h2b1a_2125));
    rst_ni               = 1'b0;
    req_i                = 1'b0;
    we_i                 = 1'b0;
    sel_line_i           = 1'b0;
    way_i                = '0;
    addr_i               = '0;
    wdata_i              = '0;
    invalidate_i         = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    cur_key              = ic_pkg::RST_KEY;
    cur_nonce            = ic_pkg::RST_NONCE;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_and_readback();
    back_to_back_reads();
    rekey_stall();
    old_key_reads();
    repeat_invalidate();
    @(negedge clk_i);
    if (UUT.u_chk.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Bus protocol assertions failed %0d times", UUT.u_chk.fail_count);
      $display("test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== build.f ====
rtl/ic_pkg.sv
rtl/ic_ram_if.sv
rtl/ic_scramble_ctrl.sv
rtl/ic_scr_ram.sv
rtl/ic_bank_select.sv
rtl/ic_ram_top.sv
bench/ic_ram_chk.sv
bench/ic_ram_tb.sv

// ==== Bender.yml ====
package:
  name: ic_ram

sources:
  - rtl/ic_pkg.sv
  - rtl/ic_ram_if.sv
  - rtl/ic_scramble_ctrl.sv
  - rtl/ic_scr_ram.sv
  - rtl/ic_bank_select.sv
  - rtl/ic_ram_top.sv
  - target: test
    files:
      - bench/ic_ram_chk.sv
      - bench/ic_ram_tb.sv
